// ==== valu.f ====
hdl/valu_types_pkg.sv
hdl/valu_op_pkg.sv
hdl/valu_issue_if.sv
hdl/valu_decode.sv
hdl/valu_add_min_max.sv
hdl/valu_bitwise.sv
hdl/valu_result.sv
hdl/valu.sv
dv/valu_chk.sv
dv/valu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the valu testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module valu_tb -f valu.f -o valu_sim \
    && ./obj_dir/valu_sim | tee /dev/stderr | grep -q "NO ERRORS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== dv/valu_tb.sv ====
`timescale 1ns/1ps

module valu_tb;
    import valu_types_pkg::*;
    import valu_op_pkg::*;

    localparam int pipe_depth = 4;
    localparam int n_rand     = 8;
    localparam int n_mixed    = 64;
    // add/sub, min/max, logic and move, merge, mixed, unsupported
    localparam int n_req = 8 * n_rand + 8 + 16 * n_rand + 32 + 4 * n_rand + 2 * n_rand
                         + n_mixed + 3 * n_rand;

    typedef struct packed {
        data_t       data;
        sew_t        sew;
        addr_t       addr;
        be_t         be;
        logic        first;
        logic        last;
        logic [31:0] due;
    } exp_t;

    logic     clk;
    logic     rst;
    logic     req_valid;
    op_mnr_t  req_op_mnr;
    func_id_t req_func_id;
    sew_t     req_sew;
    data_t    req_data0;
    data_t    req_data1;
    addr_t    req_addr;
    be_t      req_be;
    logic     req_start;
    logic     req_end;
    logic     req_mask;
    logic     resp_valid;
    data_t    resp_data;
    sew_t     resp_sew;
    addr_t    resp_addr;
    be_t      resp_be;
    logic     resp_start;
    logic     resp_end;

    exp_t        exp_q [$];
    exp_t        rec;
    int unsigned cyc = 0;
    logic [31:0] rng = 32'h796f;

    valu #(.pipe_depth(pipe_depth)) i_valu (.*);

    always #50 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1; // edges seen so far

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic data_t rand64();
        return {next_rand(), next_rand()};
    endfunction

    function automatic be_t rand_be();
        return be_t'(next_rand());
    endfunction

    function automatic op_mnr_t rand_int_class();
        logic [31:0] r;
        r = next_rand();
        return {r[1], r[0], r[0]};
    endfunction

    function automatic func_id_t pick_fn(int idx);
        case (idx)
            0: return fn_add;
            1: return fn_sub;
            2: return fn_minu;
            3: return fn_min;
            4: return fn_maxu;
            5: return fn_max;
            6: return fn_and;
            7: return fn_or;
            8: return fn_xor;
            default: return fn_merge;
        endcase
    endfunction

    function automatic logic is_supported(func_id_t fn, op_mnr_t mnr);
        logic listed;
        case (fn)
            fn_add, fn_sub, fn_minu, fn_min, fn_maxu, fn_max,
            fn_and, fn_or, fn_xor, fn_merge: listed = 1'b1;
            default: listed = 1'b0;
        endcase
        return listed && (mnr[1] == mnr[0]);
    endfunction

    // result is data1 op data0, element by element at the sew width
    function automatic data_t valu_ref(func_id_t fn, logic mask, sew_t sew,
                                       data_t d0, data_t d1, be_t be);
        data_t res;
        data_t emask;
        data_t sbit;
        data_t a;
        data_t b;
        data_t r;
        int    ew;
        res   = '0;
        ew    = 8 << sew;
        emask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
        sbit  = 64'd1 << (ew - 1); // flipping the sign bit turns signed order into unsigned
        case (fn)
            fn_and: res = d1 & d0;
            fn_or:  res = d1 | d0;
            fn_xor: res = d1 ^ d0;
            fn_merge: begin
                for (int i = 0; i < 8; i++) begin
                    res[8*i +: 8] = (mask || be[i]) ? d0[8*i +: 8] : d1[8*i +: 8];
                end
            end
            default: begin
                for (int e = 0; e < 64 / ew; e++) begin
                    a = (d1 >> (e * ew)) & emask;
                    b = (d0 >> (e * ew)) & emask;
                    case (fn)
                        fn_add:  r = (a + b) & emask;
                        fn_sub:  r = (a - b) & emask;
                        fn_minu: r = (a < b) ? a : b;
                        fn_maxu: r = (a < b) ? b : a;
                        fn_min:  r = ((a ^ sbit) < (b ^ sbit)) ? a : b;
                        fn_max:  r = ((a ^ sbit) < (b ^ sbit)) ? b : a;
                        default: r = '0;
                    endcase
                    res = res | (r << (e * ew));
                end
            end
        endcase
        return res;
    endfunction

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(string name, data_t exp, data_t act);
        if (act !== exp) begin
            $display("Error %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t act);
        if (act !== exp) begin
            $display("Error %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_be(string name, be_t exp, be_t act);
        if (act !== exp) begin
            $display("Error %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_sew(string name, sew_t exp, sew_t act);
        if (act !== exp) begin
            $display("Error %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Error %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic send_req(func_id_t fn, op_mnr_t mnr, sew_t sew, data_t d0, data_t d1,
                            be_t be, logic mask, logic valid);
        exp_t        e;
        addr_t       addr;
        logic [31:0] r;
        addr = next_rand();
        r    = next_rand();
        @(posedge clk);
        req_valid   <= valid;
        req_op_mnr  <= mnr;
        req_func_id <= fn;
        req_sew     <= sew;
        req_data0   <= d0;
        req_data1   <= d1;
        req_addr    <= addr;
        req_be      <= be;
        req_start   <= r[0];
        req_end     <= r[1];
        req_mask    <= mask;
        if (valid && is_supported(fn, mnr)) begin
            e.data  = valu_ref(fn, mask, sew, d0, d1, be);
            e.sew   = sew;
            e.addr  = addr;
            e.be    = be;
            e.first = r[0];
            e.last  = r[1];
            e.due   = cyc + pipe_depth + 2; // resp_valid rises pipe_depth edges after sampling
            exp_q.push_back(e);
        end
    endtask

    task automatic drive_idle();
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        drive_idle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (pipe_depth + 2) @(negedge clk); // stray responses would show up here
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (resp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("response arrived in cycle %0d with no request outstanding", cyc);
                    abort_run();
                end else begin
                    rec = exp_q.pop_front();
                    if (rec.due != cyc) begin
                        $display("response came in cycle %0d but was due in cycle %0d",
                                 cyc, rec.due);
                        abort_run();
                    end
                    check_data("resp_data", rec.data, resp_data);
                    check_addr("resp_addr", rec.addr, resp_addr);
                    check_be("resp_be", rec.be, resp_be);
                    check_sew("resp_sew", rec.sew, resp_sew);
                    check_bit("resp_start", rec.first, resp_start);
                    check_bit("resp_end", rec.last, resp_end);
                end
            end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
                $display("no response for the request due in cycle %0d", exp_q[0].due);
                abort_run();
            end
        end
    end

    initial begin
        #(n_req * 10 * 100);
        $display("watchdog expired before the tests finished");
        abort_run();
    end

    initial begin
        func_id_t    fn;
        logic [31:0] r;
        clk         = 1'b0;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_op_mnr  = '0;
        req_func_id = '0;
        req_sew     = '0;
        req_data0   = '0;
        req_data1   = '0;
        req_addr    = '0;
        req_be      = '0;
        req_start   = 1'b0;
        req_end     = 1'b0;
        req_mask    = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("resp_valid", 1'b0, resp_valid);
        check_bit("resp_start", 1'b0, resp_start);
        check_bit("resp_end", 1'b0, resp_end);
        check_data("resp_data", '0, resp_data);

        for (int s = 0; s < 4; s++) begin
            for (int i = 0; i < n_rand; i++) begin
                send_req(fn_add, rand_int_class(), sew_t'(s), rand64(), rand64(), rand_be(),
                         1'b0, 1'b1);
                send_req(fn_sub, rand_int_class(), sew_t'(s), rand64(), rand64(), rand_be(),
                         1'b1, 1'b1);
            end
            // every element wraps
            send_req(fn_add, 3'b000, sew_t'(s), 64'h0101010101010101, '1, '1, 1'b0, 1'b1);
            send_req(fn_sub, 3'b111, sew_t'(s), 64'h0101010101010101, '0, '1, 1'b0, 1'b1);
        end

        for (int f = 2; f < 6; f++) begin
            for (int s = 0; s < 4; s++) begin
                for (int i = 0; i < n_rand; i++) begin
                    send_req(pick_fn(f), rand_int_class(), sew_t'(s), rand64(), rand64(),
                             rand_be(), 1'b0, 1'b1);
                end
                send_req(pick_fn(f), 3'b011, sew_t'(s), {8{8'h7f}}, {8{8'h80}}, '1,
                         1'b0, 1'b1);
                send_req(pick_fn(f), 3'b100, sew_t'(s), 64'hfedc_ba98_7654_3210,
                         64'hfedc_ba98_7654_3210, '1, 1'b0, 1'b1);
            end
        end

        for (int f = 6; f < 9; f++) begin
            for (int i = 0; i < n_rand; i++) begin
                send_req(pick_fn(f), rand_int_class(), sew_t'(i), rand64(), rand64(),
                         rand_be(), 1'b0, 1'b1);
            end
        end
        for (int i = 0; i < n_rand; i++) begin
            send_req(fn_merge, rand_int_class(), sew_t'(i), rand64(), rand64(), rand_be(),
                     1'b1, 1'b1);
        end
        for (int i = 0; i < 2 * n_rand; i++) begin
            send_req(fn_merge, rand_int_class(), sew_t'(i), rand64(), rand64(), rand_be(),
                     1'b0, 1'b1);
        end

        for (int i = 0; i < n_mixed; i++) begin
            r = next_rand();
            send_req(pick_fn(int'(r % 10)), rand_int_class(), sew_t'(r[5:4]), rand64(),
                     rand64(), rand_be(), r[8], 1'b1);
        end
        wait_drain();

        // nothing below may give a response
        for (int i = 0; i < n_rand; i++) begin
            fn = func_id_t'(next_rand());
            while (is_supported(fn, 3'b000)) begin
                fn = func_id_t'(next_rand());
            end
            send_req(fn, rand_int_class(), sew_t'(i), rand64(), rand64(), rand_be(),
                     1'b0, 1'b1);
        end
        for (int i = 0; i < n_rand; i++) begin
            r = next_rand();
            send_req(pick_fn(i), {r[2], r[0], ~r[0]}, sew_t'(i), rand64(), rand64(),
                     rand_be(), 1'b0, 1'b1);
        end
        for (int i = 0; i < n_rand; i++) begin
            send_req(pick_fn(i), 3'b000, sew_t'(i), rand64(), rand64(), rand_be(),
                     1'b0, 1'b0);
        end
        wait_drain();

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== dv/valu_chk.sv ====
`timescale 1ns/1ps

module valu_chk #(
    parameter int pipe_depth = 4
) (
    input logic clk,
    input logic rst,
    input logic supported,
    input logic add_issue,
    input logic bit_issue,
    input logic resp_valid,
    input logic resp_start,
    input logic resp_end
);

    a_start_valid: assert property (@(posedge clk) disable iff (rst) resp_start |-> resp_valid)
        else $error("resp_start high without resp_valid");

    a_end_valid: assert property (@(posedge clk) disable iff (rst) resp_end |-> resp_valid)
        else $error("resp_end high without resp_valid");

    a_one_unit: assert property (@(posedge clk) disable iff (rst) !(add_issue && bit_issue))
        else $error("both execution units issued in the same cycle");

    // fixed latency, unit stages plus the response register
    a_latency: assert property (@(posedge clk) disable iff (rst)
        $past(supported, pipe_depth + 1) |-> resp_valid)
        else $error("supported request gave no response after pipe_depth + 1 cycles");

    a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> !resp_valid)
        else $error("resp_valid high in the first cycle after reset");

endmodule

bind valu valu_chk #(.pipe_depth(pipe_depth)) i_valu_chk (
    .clk       (clk),
    .rst       (rst),
    .supported (supported),
    .add_issue (issue.add_valid),
    .bit_issue (issue.bit_valid),
    .resp_valid(resp_valid),
    .resp_start(resp_start),
    .resp_end  (resp_end)
);

// ==== hdl/valu.sv ====
`timescale 1ns/1ps

module valu #(
    parameter int pipe_depth = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  valu_types_pkg::op_mnr_t  req_op_mnr,
    input  valu_types_pkg::func_id_t req_func_id,
    input  valu_types_pkg::sew_t     req_sew,
    input  valu_types_pkg::data_t    req_data0,
    input  valu_types_pkg::data_t    req_data1,
    input  valu_types_pkg::addr_t    req_addr,
    input  valu_types_pkg::be_t      req_be,
    input  logic                     req_start,
    input  logic                     req_end,
    input  logic                     req_mask,
    output logic                     resp_valid,
    output valu_types_pkg::data_t    resp_data,
    output valu_types_pkg::sew_t     resp_sew,
    output valu_types_pkg::addr_t    resp_addr,
    output valu_types_pkg::be_t      resp_be,
    output logic                     resp_start,
    output logic                     resp_end
);
    import valu_types_pkg::*;

    logic  supported;
    logic  add_valid;
    logic  bit_valid;
    data_t add_data;
    data_t bit_data;

    valu_issue_if issue ();

    valu_decode i_decode (
        .req_valid  (req_valid),
        .req_op_mnr (req_op_mnr),
        .req_func_id(req_func_id),
        .req_mask   (req_mask),
        .req_sew    (req_sew),
        .req_data0  (req_data0),
        .req_data1  (req_data1),
        .req_be     (req_be),
        .supported  (supported),
        .issue      (issue)
    );

    valu_add_min_max #(.pipe_depth(pipe_depth)) i_add_min_max (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .out_valid(add_valid),
        .out_data (add_data)
    );

    valu_bitwise #(.pipe_depth(pipe_depth)) i_bitwise (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .out_valid(bit_valid),
        .out_data (bit_data)
    );

    // response lands pipe_depth + 1 cycles after the request
    valu_result #(.pipe_depth(pipe_depth)) i_result (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .supported (supported),
        .req_sew   (req_sew),
        .req_addr  (req_addr),
        .req_be    (req_be),
        .req_start (req_start),
        .req_end   (req_end),
        .add_valid (add_valid),
        .add_data  (add_data),
        .bit_valid (bit_valid),
        .bit_data  (bit_data),
        .resp_valid(resp_valid),
        .resp_data (resp_data),
        .resp_sew  (resp_sew),
        .resp_addr (resp_addr),
        .resp_be   (resp_be),
        .resp_start(resp_start),
        .resp_end  (resp_end)
    );

endmodule

// ==== hdl/valu_result.sv ====
`timescale 1ns/1ps

module valu_result #(
    parameter int pipe_depth = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  logic                  supported,
    input  valu_types_pkg::sew_t  req_sew,
    input  valu_types_pkg::addr_t req_addr,
    input  valu_types_pkg::be_t   req_be,
    input  logic                  req_start,
    input  logic                  req_end,
    input  logic                  add_valid,
    input  valu_types_pkg::data_t add_data,
    input  logic                  bit_valid,
    input  valu_types_pkg::data_t bit_data,
    output logic                  resp_valid,
    output valu_types_pkg::data_t resp_data,
    output valu_types_pkg::sew_t  resp_sew,
    output valu_types_pkg::addr_t resp_addr,
    output valu_types_pkg::be_t   resp_be,
    output logic                  resp_start,
    output logic                  resp_end
);
    import valu_types_pkg::*;

    // sideband delay line, same depth as the execution units
    sew_t  sew_q  [pipe_depth];
    addr_t addr_q [pipe_depth];
    be_t   be_q   [pipe_depth];
    logic  [pipe_depth-1:0] start_q;
    logic  [pipe_depth-1:0] end_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < pipe_depth; i++) begin
                sew_q[i]  <= '0;
                addr_q[i] <= '0;
                be_q[i]   <= '0;
            end
            start_q    <= '0;
            end_q      <= '0;
            resp_valid <= 1'b0;
            resp_data  <= '0;
            resp_sew   <= '0;
            resp_addr  <= '0;
            resp_be    <= '0;
            resp_start <= 1'b0;
            resp_end   <= 1'b0;
        end else begin
            sew_q[0]   <= req_valid ? req_sew : '0;
            addr_q[0]  <= req_valid ? req_addr : '0;
            be_q[0]    <= req_valid ? req_be : '0;
            start_q[0] <= req_start & supported; // no flags for dropped requests
            end_q[0]   <= req_end & supported;
            for (int i = 1; i < pipe_depth; i++) begin
                sew_q[i]   <= sew_q[i-1];
                addr_q[i]  <= addr_q[i-1];
                be_q[i]    <= be_q[i-1];
                start_q[i] <= start_q[i-1];
                end_q[i]   <= end_q[i-1];
            end
            resp_valid <= add_valid | bit_valid;
            resp_data  <= add_data | bit_data; // idle unit drives zero
            resp_sew   <= sew_q[pipe_depth-1];
            resp_addr  <= addr_q[pipe_depth-1];
            resp_be    <= be_q[pipe_depth-1];
            resp_start <= start_q[pipe_depth-1];
            resp_end   <= end_q[pipe_depth-1];
        end
    end

endmodule

// ==== hdl/valu_bitwise.sv ====
`timescale 1ns/1ps

module valu_bitwise #(
    parameter int pipe_depth = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    valu_issue_if.unit            issue,
    output logic                  out_valid,
    output valu_types_pkg::data_t out_data
);
    import valu_types_pkg::*;
    import valu_op_pkg::*;

    data_t merged;
    data_t op_res;
    data_t data_q [pipe_depth];
    logic  [pipe_depth-1:0] valid_q;

    // per byte select, be set takes data0
    always_comb begin
        for (int b = 0; b < be_w; b++) begin
            merged[b*8 +: 8] = issue.be[b] ? issue.data0[b*8 +: 8] : issue.data1[b*8 +: 8];
        end
    end

    always_comb begin
        case (issue.bit_op)
            bit_op_and:   op_res = issue.data1 & issue.data0;
            bit_op_or:    op_res = issue.data1 | issue.data0;
            bit_op_xor:   op_res = issue.data1 ^ issue.data0;
            bit_op_move:  op_res = issue.data0;
            bit_op_merge: op_res = merged;
            default:      op_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            for (int i = 0; i < pipe_depth; i++) begin
                data_q[i] <= '0;
            end
        end else begin
            valid_q[0] <= issue.bit_valid;
            data_q[0]  <= issue.bit_valid ? op_res : '0;
            for (int i = 1; i < pipe_depth; i++) begin
                valid_q[i] <= valid_q[i-1];
                data_q[i]  <= data_q[i-1];
            end
        end
    end

    assign out_valid = valid_q[pipe_depth-1];
    assign out_data  = data_q[pipe_depth-1];

endmodule

// ==== hdl/valu_add_min_max.sv ====
`timescale 1ns/1ps

module valu_add_min_max #(
    parameter int pipe_depth = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    valu_issue_if.unit            issue,
    output logic                  out_valid,
    output valu_types_pkg::data_t out_data
);
    import valu_types_pkg::*;
    import valu_op_pkg::*;

    logic  signed_cmp;
    data_t elem_res;
    data_t data_q [pipe_depth];
    logic  [pipe_depth-1:0] valid_q;

    // one result word per element width, picked by sew below
    wire data_t res_by_sew [n_sew];

    assign signed_cmp = (issue.add_op == add_op_min) || (issue.add_op == add_op_max);

    for (genvar s = 0; s < n_sew; s++) begin : g_sew
        localparam int ew = 8 << s;

        for (genvar e = 0; e < data_w / ew; e++) begin : g_elem
            logic [ew-1:0] a;
            logic [ew-1:0] b;
            logic [ew-1:0] pick;
            logic          less;

            assign a = issue.data1[e*ew +: ew]; // data1 is the left operand
            assign b = issue.data0[e*ew +: ew];

            assign less = signed_cmp ? ($signed(a) < $signed(b)) : (a < b);

            always_comb begin
                case (issue.add_op)
                    add_op_add:  pick = a + b; // wraps inside the element
                    add_op_sub:  pick = a - b;
                    add_op_minu,
                    add_op_min:  pick = less ? a : b;
                    add_op_maxu,
                    add_op_max:  pick = less ? b : a;
                    default:     pick = '0;
                endcase
            end

            assign res_by_sew[s][e*ew +: ew] = pick;
        end
    end

    assign elem_res = res_by_sew[issue.sew];

    // stage 0 holds the computed result, the rest only shift
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            for (int i = 0; i < pipe_depth; i++) begin
                data_q[i] <= '0;
            end
        end else begin
            valid_q[0] <= issue.add_valid;
            data_q[0]  <= issue.add_valid ? elem_res : '0; // keeps the or in valu_result clean
            for (int i = 1; i < pipe_depth; i++) begin
                valid_q[i] <= valid_q[i-1];
                data_q[i]  <= data_q[i-1];
            end
        end
    end

    assign out_valid = valid_q[pipe_depth-1];
    assign out_data  = data_q[pipe_depth-1];

endmodule

// ==== hdl/valu_decode.sv ====
`timescale 1ns/1ps

module valu_decode (
    input  logic                     req_valid,
    input  valu_types_pkg::op_mnr_t  req_op_mnr,
    input  valu_types_pkg::func_id_t req_func_id,
    input  logic                     req_mask,
    input  valu_types_pkg::sew_t     req_sew,
    input  valu_types_pkg::data_t    req_data0,
    input  valu_types_pkg::data_t    req_data1,
    input  valu_types_pkg::be_t      req_be,
    output logic                     supported,
    valu_issue_if.decode             issue
);
    import valu_op_pkg::*;

    logic    int_class;
    logic    is_add;
    logic    is_bit;
    add_op_t add_sel;
    bit_op_t bit_sel;

    assign int_class = (req_op_mnr[1] == req_op_mnr[0]);

    always_comb begin
        is_add  = 1'b1;
        is_bit  = 1'b0;
        add_sel = add_op_add;
        bit_sel = bit_op_and;
        case (req_func_id)
            fn_add:  add_sel = add_op_add;
            fn_sub:  add_sel = add_op_sub;
            fn_minu: add_sel = add_op_minu;
            fn_min:  add_sel = add_op_min;
            fn_maxu: add_sel = add_op_maxu;
            fn_max:  add_sel = add_op_max;
            fn_and, fn_or, fn_xor: begin
                is_add  = 1'b0;
                is_bit  = 1'b1;
                bit_sel = (req_func_id == fn_and) ? bit_op_and :
                          (req_func_id == fn_or)  ? bit_op_or  : bit_op_xor;
            end
            fn_merge: begin
                is_add  = 1'b0;
                is_bit  = 1'b1;
                bit_sel = req_mask ? bit_op_move : bit_op_merge; // mask set means plain move
            end
            default: is_add = 1'b0; // not handled by this slice
        endcase
    end

    assign supported = req_valid & int_class & (is_add | is_bit);

    // at most one unit valid, is_add and is_bit are exclusive
    assign issue.add_valid = supported & is_add;
    assign issue.bit_valid = supported & is_bit;
    assign issue.add_op    = add_sel;
    assign issue.bit_op    = bit_sel;
    assign issue.sew       = req_sew;
    assign issue.data0     = req_data0;
    assign issue.data1     = req_data1;
    assign issue.be        = req_be;

endmodule

// ==== hdl/valu_issue_if.sv ====
`timescale 1ns/1ps

// decoded request, one cycle wide, shared by both execution units
interface valu_issue_if;
    import valu_types_pkg::*;
    import valu_op_pkg::*;

    logic    add_valid; // adder unit takes this request
    logic    bit_valid; // bitwise unit takes this request
    add_op_t add_op;
    bit_op_t bit_op;
    sew_t    sew;
    data_t   data0;
    data_t   data1;
    be_t     be;

    modport decode (
        output add_valid, bit_valid, add_op, bit_op,
        output sew, data0, data1, be
    );

    modport unit (
        input add_valid, bit_valid, add_op, bit_op,
        input sew, data0, data1, be
    );

endinterface

// ==== hdl/valu_op_pkg.sv ====
package valu_op_pkg;

    // function ids as they arrive on req_func_id
    localparam valu_types_pkg::func_id_t fn_add   = 6'b000000;
    localparam valu_types_pkg::func_id_t fn_sub   = 6'b000010;
    localparam valu_types_pkg::func_id_t fn_minu  = 6'b000100;
    localparam valu_types_pkg::func_id_t fn_min   = 6'b000101;
    localparam valu_types_pkg::func_id_t fn_maxu  = 6'b000110;
    localparam valu_types_pkg::func_id_t fn_max   = 6'b000111;
    localparam valu_types_pkg::func_id_t fn_and   = 6'b001001;
    localparam valu_types_pkg::func_id_t fn_or    = 6'b001010;
    localparam valu_types_pkg::func_id_t fn_xor   = 6'b001011;
    localparam valu_types_pkg::func_id_t fn_merge = 6'b010111; // move when mask set

    // adder unit select
    typedef logic [2:0] add_op_t;

    localparam add_op_t add_op_add  = 3'd0;
    localparam add_op_t add_op_sub  = 3'd1;
    localparam add_op_t add_op_minu = 3'd2;
    localparam add_op_t add_op_min  = 3'd3;
    localparam add_op_t add_op_maxu = 3'd4;
    localparam add_op_t add_op_max  = 3'd5;

    // bitwise unit select
    typedef logic [2:0] bit_op_t;

    localparam bit_op_t bit_op_and   = 3'd0;
    localparam bit_op_t bit_op_or    = 3'd1;
    localparam bit_op_t bit_op_xor   = 3'd2;
    localparam bit_op_t bit_op_move  = 3'd3;
    localparam bit_op_t bit_op_merge = 3'd4;

endpackage

// ==== hdl/valu_types_pkg.sv ====
package valu_types_pkg;

    // one 64-bit register chunk per request
    localparam int data_w = 64;
    localparam int be_w   = data_w / 8;
    localparam int addr_w = 32;

    // number of element widths, 8/16/32/64
    localparam int n_sew = 4;

    // operand or result chunk
    typedef logic [data_w-1:0] data_t;

    typedef logic [be_w-1:0] be_t; // one bit per byte

    // 0, 1, 2, 3 -> 8, 16, 32, 64 bit elements
    typedef logic [1:0] sew_t;

    typedef logic [addr_w-1:0] addr_t; // destination tag

    typedef logic [5:0] func_id_t;

    // minor opcode, integer class when bits 1 and 0 agree
    typedef logic [2:0] op_mnr_t;

endpackage
